// ==== design/dsp_pkg.sv ====
`default_nettype none

package dsp_pkg;

  typedef logic [15:0] data_t;
  typedef logic [23:0] insn_word_t;

  typedef enum logic [1:0] {
    CLS_OP = 2'b00,
    CLS_RT = 2'b01,
    CLS_JP = 2'b10,
    CLS_LD = 2'b11
  } insn_cls_e;

  typedef enum logic [4:0] {
    PH_FETCH     = 5'b00001,
    PH_LOAD      = 5'b00010,
    PH_OPERAND   = 5'b00100,
    PH_EXECUTE   = 5'b01000,
    PH_WRITEBACK = 5'b10000
  } phase_e;

  typedef enum logic [3:0] {
    ALU_NOP, ALU_OR, ALU_AND, ALU_XOR,
    ALU_SUB, ALU_ADD, ALU_SBB, ALU_ADC,
    ALU_DEC, ALU_INC, ALU_NOT, ALU_SAR1,
    ALU_RCL1, ALU_SLL2, ALU_SLL4, ALU_XCHG
  } alu_op_e;

  // bus sources, unlisted codes read zero
  typedef enum logic [3:0] {
    SRC_TRB = 4'h0,
    SRC_A   = 4'h1,
    SRC_B   = 4'h2,
    SRC_TR  = 4'h3,
    SRC_RP  = 4'h5,
    SRC_ROM = 4'h6,
    SRC_DR  = 4'h8,
    SRC_K   = 4'hd,
    SRC_L   = 4'he
  } src_e;

  typedef enum logic [3:0] {
    DST_A   = 4'h1,
    DST_B   = 4'h2,
    DST_TR  = 4'h3,
    DST_RP  = 4'h5,
    DST_DR  = 4'h6,
    DST_K   = 4'ha,
    DST_KLR = 4'hb,  // K from bus, L from data ROM
    DST_L   = 4'hd,
    DST_TRB = 4'he
  } dst_e;

  typedef enum logic [1:0] {
    PSEL_ZERO = 2'b00,
    PSEL_IDB  = 2'b01,
    PSEL_M    = 2'b10,
    PSEL_N    = 2'b11
  } psel_e;

  typedef struct packed {
    insn_cls_e   cls;
    psel_e       psel;
    alu_op_e     alu;
    logic        asl;  // 0 = A, 1 = B
    logic        rpdcr;
    src_e        src;
    dst_e        dst;
    logic [8:0]  brch;
    logic [10:0] na;
    data_t       imm;
  } insn_t;

  typedef struct packed {
    logic z;
    logic c;
    logic s0;
    logic ov0;
  } flags_t;

  localparam logic [8:0] BR_JMP  = 9'b100_000_000;
  localparam logic [8:0] BR_CALL = 9'b101_000_000;
  localparam logic [8:0] BR_COND = 9'b010_000_000;  // + flag group, acc, polarity

endpackage

`default_nettype wire

// ==== design/dsp_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_mem #(
  parameter type word_t = logic [15:0],
  parameter int  ADDR_W = 10
) (
  input  wire              CLK,
  input  wire              wr,
  input  wire [ADDR_W-1:0] wr_addr,
  input  wire word_t       wr_data,
  input  wire [ADDR_W-1:0] rd_addr,
  output word_t            rd_data
);

  word_t mem [2**ADDR_W];

  always_ff @(posedge CLK) begin
    if (wr) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];  // one cycle latency
  end

endmodule

`default_nettype wire

// ==== design/dsp_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_sequencer #(
  parameter int PC_W    = 11,
  parameter int STACK_D = 4
) (
  input  wire                      CLK,
  input  wire                      RST,
  input  wire dsp_pkg::insn_word_t opcode,
  input  wire dsp_pkg::flags_t     flags_a,
  input  wire dsp_pkg::flags_t     flags_b,
  input  wire                      rqm,
  output logic [PC_W-1:0]          pc,
  output dsp_pkg::insn_t           insn,
  output dsp_pkg::phase_e          phase
);

  localparam int SP_W = $clog2(STACK_D);

  logic [PC_W-1:0] stack [STACK_D];
  logic [SP_W-1:0] sp;
  logic            cond;
  logic            cond_next;
  logic            push;
  dsp_pkg::flags_t fsel;

  // all classes share one bit split, unused fields are ignored
  function automatic dsp_pkg::insn_t decode(input dsp_pkg::insn_word_t w);
    dsp_pkg::insn_t d;
    d.cls   = dsp_pkg::insn_cls_e'(w[23:22]);
    d.psel  = dsp_pkg::psel_e'(w[21:20]);
    d.alu   = dsp_pkg::alu_op_e'(w[19:16]);
    d.asl   = w[15];
    d.rpdcr = w[8];
    d.src   = dsp_pkg::src_e'(w[7:4]);
    d.dst   = dsp_pkg::dst_e'(w[3:0]);
    d.brch  = w[21:13];
    d.na    = w[12:2];
    d.imm   = w[21:6];
    return d;
  endfunction

  //////////////////////////////////////////////////
  // branch condition

  assign fsel = insn.brch[2] ? flags_b : flags_a;

  always_comb begin
    cond_next = 1'b0;
    if (insn.brch == dsp_pkg::BR_JMP || insn.brch == dsp_pkg::BR_CALL) begin
      cond_next = 1'b1;
    end else if (insn.brch[8:6] == dsp_pkg::BR_COND[8:6] && !insn.brch[0]) begin
      case (insn.brch[5:3])  // brch[1] gives the tested polarity
        3'b000:  cond_next = (fsel.c == insn.brch[1]);
        3'b001:  cond_next = (fsel.z == insn.brch[1]);
        3'b100:  cond_next = (fsel.s0 == insn.brch[1]);
        3'b111:  cond_next = insn.brch[2] && (rqm == insn.brch[1]);
        default: cond_next = 1'b0;
      endcase
    end
  end

  assign push = phase == dsp_pkg::PH_EXECUTE && insn.cls == dsp_pkg::CLS_JP &&
                cond && insn.brch == dsp_pkg::BR_CALL;

  //////////////////////////////////////////////////
  // phase ring and pc

  always_ff @(posedge CLK) begin
    if (RST) begin
      phase <= dsp_pkg::PH_FETCH;
      pc    <= '0;
      sp    <= '0;
      cond  <= 1'b0;
      insn  <= '0;
    end else begin
      case (phase)
        dsp_pkg::PH_FETCH: begin
          phase <= dsp_pkg::PH_LOAD;
          insn  <= decode(opcode);
        end
        dsp_pkg::PH_LOAD: begin
          phase <= dsp_pkg::PH_OPERAND;
        end
        dsp_pkg::PH_OPERAND: begin
          phase <= dsp_pkg::PH_EXECUTE;
          cond  <= cond_next;
        end
        dsp_pkg::PH_EXECUTE: begin
          phase <= dsp_pkg::PH_WRITEBACK;
          pc    <= pc + 1'b1;
          if (insn.cls == dsp_pkg::CLS_RT) begin
            pc <= stack[sp - 1'b1];  // pop
            sp <= sp - 1'b1;
          end else if (insn.cls == dsp_pkg::CLS_JP && cond) begin
            pc <= insn.na[PC_W-1:0];
            if (push) begin
              sp <= sp + 1'b1;
            end
          end
        end
        default: begin
          phase <= dsp_pkg::PH_FETCH;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      stack[sp] <= pc + 1'b1;  // return address
    end
  end

endmodule

`default_nettype wire

// ==== design/dsp_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_datapath #(
  parameter int ROM_W = 10
) (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire dsp_pkg::insn_t  insn,
  input  wire dsp_pkg::phase_e phase,
  input  wire dsp_pkg::data_t  acc_a,
  input  wire dsp_pkg::data_t  acc_b,
  input  wire dsp_pkg::data_t  rom_data,
  input  wire                  host_wr,
  input  wire dsp_pkg::data_t  host_di,
  input  wire                  host_rd,
  output dsp_pkg::data_t       idb,
  output logic [ROM_W-1:0]     rp,
  output dsp_pkg::data_t       dr,
  output logic                 rqm
);

  dsp_pkg::data_t     bus;   // latched in LOAD
  dsp_pkg::data_t     tr;
  dsp_pkg::data_t     trb;
  dsp_pkg::data_t     k;
  dsp_pkg::data_t     l;
  dsp_pkg::data_t     m;
  dsp_pkg::data_t     n;
  dsp_pkg::data_t     wval;
  logic signed [31:0] prod;
  logic               op_en;
  logic               mv_en;
  logic               exec;

  assign op_en = !insn.cls[1];  // OP or RT
  assign mv_en = insn.cls != dsp_pkg::CLS_JP;
  assign exec  = phase == dsp_pkg::PH_EXECUTE;
  assign wval  = (insn.cls == dsp_pkg::CLS_LD) ? insn.imm : bus;
  assign prod  = $signed(k) * $signed(l);

  // P operand rides on idb while the ALU samples it
  always_comb begin
    idb = bus;
    if (phase == dsp_pkg::PH_OPERAND) begin
      case (insn.psel)
        dsp_pkg::PSEL_ZERO: idb = '0;  // no data RAM
        dsp_pkg::PSEL_M:    idb = m;
        dsp_pkg::PSEL_N:    idb = n;
        default:            idb = bus;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (phase == dsp_pkg::PH_LOAD && op_en) begin
      case (insn.src)
        dsp_pkg::SRC_TRB: bus <= trb;
        dsp_pkg::SRC_A:   bus <= acc_a;
        dsp_pkg::SRC_B:   bus <= acc_b;
        dsp_pkg::SRC_TR:  bus <= tr;
        dsp_pkg::SRC_RP:  bus <= dsp_pkg::data_t'(rp);
        dsp_pkg::SRC_ROM: bus <= rom_data;
        dsp_pkg::SRC_DR:  bus <= dr;
        dsp_pkg::SRC_K:   bus <= k;
        dsp_pkg::SRC_L:   bus <= l;
        default:          bus <= '0;
      endcase
    end
    if (phase == dsp_pkg::PH_FETCH) begin
      m <= {prod[31], prod[29:15]};
      n <= {prod[14:0], 1'b0};
    end
  end

  //////////////////////////////////////////////////
  // destination registers

  always_ff @(posedge CLK) begin
    if (RST) begin
      tr  <= '0;
      trb <= '0;
      rp  <= '0;
      k   <= '0;
      l   <= '0;
    end else begin
      if (exec && mv_en) begin
        case (insn.dst)
          dsp_pkg::DST_TR:  tr  <= wval;
          dsp_pkg::DST_TRB: trb <= wval;
          dsp_pkg::DST_RP:  rp  <= wval[ROM_W-1:0];
          dsp_pkg::DST_K:   k   <= wval;
          dsp_pkg::DST_L:   l   <= wval;
          dsp_pkg::DST_KLR: begin
            k <= wval;
            l <= rom_data;
          end
          default: ;
        endcase
      end
      if (exec && op_en && insn.rpdcr) begin
        rp <= rp - 1'b1;  // post-decrement wins over a move
      end
    end
  end

  // host port, strobes take priority
  always_ff @(posedge CLK) begin
    if (RST) begin
      dr  <= '0;
      rqm <= 1'b0;
    end else begin
      if (host_wr) begin
        dr <= host_di;
      end else if (exec && mv_en && insn.dst == dsp_pkg::DST_DR) begin
        dr <= wval;
      end
      if (host_wr || host_rd) begin
        rqm <= 1'b0;
      end else if (exec && ((op_en && insn.src == dsp_pkg::SRC_DR) ||
                            (mv_en && insn.dst == dsp_pkg::DST_DR))) begin
        rqm <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/dsp_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_alu (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire dsp_pkg::insn_t  insn,
  input  wire dsp_pkg::phase_e phase,
  input  wire dsp_pkg::data_t  idb,
  output dsp_pkg::data_t       acc_a,
  output dsp_pkg::data_t       acc_b,
  output dsp_pkg::flags_t      flags_a,
  output dsp_pkg::flags_t      flags_b
);

  dsp_pkg::data_t  acc [2];
  dsp_pkg::flags_t flg [2];
  dsp_pkg::data_t  p;
  dsp_pkg::data_t  q;
  dsp_pkg::data_t  r;
  dsp_pkg::data_t  mval;
  dsp_pkg::flags_t fnew;
  logic            cin;
  logic            alu_en;
  logic            moved;

  assign acc_a   = acc[0];
  assign acc_b   = acc[1];
  assign flags_a = flg[0];
  assign flags_b = flg[1];
  assign cin     = flg[!insn.asl].c;  // carry of the other accumulator
  assign alu_en  = !insn.cls[1] && insn.alu != dsp_pkg::ALU_NOP;
  assign mval    = (insn.cls == dsp_pkg::CLS_LD) ? insn.imm : idb;
  // bus move to the same accumulator keeps the ALU result out
  assign moved   = insn.dst == (insn.asl ? dsp_pkg::DST_B : dsp_pkg::DST_A);

  always_ff @(posedge CLK) begin
    if (phase == dsp_pkg::PH_OPERAND) begin
      q <= acc[insn.asl];
      p <= (insn.alu == dsp_pkg::ALU_DEC || insn.alu == dsp_pkg::ALU_INC) ? 16'h0001 : idb;
    end
    if (phase == dsp_pkg::PH_EXECUTE) begin
      case (insn.alu)
        dsp_pkg::ALU_OR:   r <= q | p;
        dsp_pkg::ALU_AND:  r <= q & p;
        dsp_pkg::ALU_XOR:  r <= q ^ p;
        dsp_pkg::ALU_SUB,
        dsp_pkg::ALU_DEC:  r <= q - p;
        dsp_pkg::ALU_ADD,
        dsp_pkg::ALU_INC:  r <= q + p;
        dsp_pkg::ALU_SBB:  r <= q - p - cin;
        dsp_pkg::ALU_ADC:  r <= q + p + cin;
        dsp_pkg::ALU_NOT:  r <= ~q;
        dsp_pkg::ALU_SAR1: r <= {q[15], q[15:1]};
        dsp_pkg::ALU_RCL1: r <= {q[14:0], cin};
        dsp_pkg::ALU_SLL2: r <= {q[13:0], 2'b11};
        dsp_pkg::ALU_SLL4: r <= {q[11:0], 4'b1111};
        dsp_pkg::ALU_XCHG: r <= {q[7:0], q[15:8]};
        default:           r <= q;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // flags

  always_comb begin
    fnew.z   = (r == '0);
    fnew.s0  = r[15];
    fnew.c   = 1'b0;  // logic ops, NOT, SLL2/4, XCHG
    fnew.ov0 = 1'b0;
    case (insn.alu)
      dsp_pkg::ALU_ADD, dsp_pkg::ALU_ADC, dsp_pkg::ALU_INC: begin
        fnew.c   = r < q;
        fnew.ov0 = (q[15] ^ r[15]) & ~(q[15] ^ p[15]);
      end
      dsp_pkg::ALU_SUB, dsp_pkg::ALU_SBB, dsp_pkg::ALU_DEC: begin
        fnew.c   = r > q;  // borrow
        fnew.ov0 = (q[15] ^ r[15]) & (q[15] ^ p[15]);
      end
      dsp_pkg::ALU_SAR1: fnew.c = q[0];
      dsp_pkg::ALU_RCL1: fnew.c = q[15];
      default: ;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      acc[0] <= '0;
      acc[1] <= '0;
      flg[0] <= '0;
      flg[1] <= '0;
    end else begin
      if (phase == dsp_pkg::PH_EXECUTE && insn.cls != dsp_pkg::CLS_JP) begin
        if (insn.dst == dsp_pkg::DST_A) begin
          acc[0] <= mval;
        end
        if (insn.dst == dsp_pkg::DST_B) begin
          acc[1] <= mval;
        end
      end
      if (phase == dsp_pkg::PH_WRITEBACK && alu_en) begin
        flg[insn.asl] <= fnew;
        if (!moved) begin
          acc[insn.asl] <= r;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/dsp_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_core #(
  parameter int PC_W    = 11,
  parameter int ROM_W   = 10,
  parameter int STACK_D = 4
) (
  input  wire                      CLK,
  input  wire                      RST,
  input  wire                      pgm_wr,
  input  wire [PC_W-1:0]           pgm_addr,
  input  wire dsp_pkg::insn_word_t pgm_data,
  input  wire                      dat_wr,
  input  wire [ROM_W-1:0]          dat_addr,
  input  wire dsp_pkg::data_t      dat_data,
  input  wire                      host_wr,
  input  wire dsp_pkg::data_t      host_di,
  input  wire                      host_rd,
  output wire dsp_pkg::data_t      dr,
  output wire                      rqm
);

  logic [PC_W-1:0]     pc;
  logic [ROM_W-1:0]    rp;
  dsp_pkg::insn_word_t opcode;
  dsp_pkg::data_t      rom_data;
  dsp_pkg::insn_t      insn;
  dsp_pkg::phase_e     phase;
  dsp_pkg::data_t      idb;
  dsp_pkg::data_t      acc_a;
  dsp_pkg::data_t      acc_b;
  dsp_pkg::flags_t     flags_a;
  dsp_pkg::flags_t     flags_b;

  //////////////////////////////////////////////////
  // memories, loaded by the host during reset

  dsp_mem #(.word_t(dsp_pkg::insn_word_t), .ADDR_W(PC_W)) u_pgm (
    .CLK(CLK), .wr(pgm_wr), .wr_addr(pgm_addr), .wr_data(pgm_data),
    .rd_addr(pc), .rd_data(opcode)
  );

  dsp_mem #(.word_t(dsp_pkg::data_t), .ADDR_W(ROM_W)) u_rom (
    .CLK(CLK), .wr(dat_wr), .wr_addr(dat_addr), .wr_data(dat_data),
    .rd_addr(rp), .rd_data(rom_data)
  );

  dsp_sequencer #(.PC_W(PC_W), .STACK_D(STACK_D)) u_seq (
    .CLK(CLK), .RST(RST), .opcode(opcode), .flags_a(flags_a), .flags_b(flags_b),
    .rqm(rqm), .pc(pc), .insn(insn), .phase(phase)
  );

  dsp_datapath #(.ROM_W(ROM_W)) u_dp (
    .CLK(CLK), .RST(RST), .insn(insn), .phase(phase), .acc_a(acc_a), .acc_b(acc_b),
    .rom_data(rom_data), .host_wr(host_wr), .host_di(host_di), .host_rd(host_rd),
    .idb(idb), .rp(rp), .dr(dr), .rqm(rqm)
  );

  dsp_alu u_alu (
    .CLK(CLK), .RST(RST), .insn(insn), .phase(phase), .idb(idb),
    .acc_a(acc_a), .acc_b(acc_b), .flags_a(flags_a), .flags_b(flags_b)
  );

endmodule

`default_nettype wire

// ==== tests/dsp_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_checker (
  input  wire                 CLK,
  input  wire                 chk,      // one-cycle expect strobe
  input  wire dsp_pkg::data_t exp_dr,
  input  wire                 exp_rqm,
  input  wire dsp_pkg::data_t dr,
  input  wire                 rqm,
  output int                  checks,
  output int                  errors
);

  initial begin
    checks = 0;
    errors = 0;
  end

  always @(posedge CLK) begin
    if (chk) begin
      checks = checks + 1;
      if (dr !== exp_dr) begin
        $display("ERROR dr: expected %h got %h", exp_dr, dr);
        errors = errors + 1;
      end
      if (rqm !== exp_rqm) begin
        $display("ERROR rqm: expected %h got %h", exp_rqm, rqm);
        errors = errors + 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/dsp_core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_core_assert (
  input wire       CLK,
  input wire       RST,
  input wire       host_rd,
  input wire       rqm,
  input wire [4:0] phase
);

  // host read always clears the request flag
  rd_clears_rqm: assert property (@(posedge CLK) disable iff (RST) host_rd |=> !rqm)
    else $error("rqm still set after host_rd");

  rst_clears_rqm: assert property (@(posedge CLK) RST |=> !rqm)
    else $error("rqm set after reset");

  phase_onehot: assert property (@(posedge CLK) disable iff (RST) $onehot(phase))
    else $error("phase not one-hot");

endmodule

bind dsp_datapath dsp_core_assert u_assert (
  .CLK(CLK), .RST(RST), .host_rd(host_rd), .rqm(rqm), .phase(phase)
);

`default_nettype wire

// ==== tests/tb_dsp_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_core;

  localparam int NVEC = 20;
  localparam logic [8:0] BR_RQM_SET = dsp_pkg::BR_COND | 9'b000_111_110;
  localparam logic [8:0] BR_ZA_SET  = dsp_pkg::BR_COND | 9'b000_001_010;

  typedef struct packed {
    dsp_pkg::insn_word_t [7:0] prog;
    logic [1:0]                nexp;
    dsp_pkg::data_t [2:0]      exp_dr;
    logic                      wr_en;   // host write instead of host read
    logic [1:0]                wr_step;
    dsp_pkg::data_t            wr_val;
    logic [9:0]                rom_addr;
    dsp_pkg::data_t [1:0]      rom_val; // words at rom_addr and rom_addr-1
  } vec_t;

  logic CLK, RST, pgm_wr, dat_wr, host_wr, host_rd;
  logic [10:0] pgm_addr;
  logic [9:0] dat_addr;
  dsp_pkg::insn_word_t pgm_data;
  dsp_pkg::data_t dat_data, host_di, dr, exp_dr;
  logic rqm, chk, exp_rqm;
  int checks, errors, timeouts;
  vec_t vecs [NVEC];

  dsp_core UUT (
    .CLK(CLK), .RST(RST), .pgm_wr(pgm_wr), .pgm_addr(pgm_addr), .pgm_data(pgm_data),
    .dat_wr(dat_wr), .dat_addr(dat_addr), .dat_data(dat_data), .host_wr(host_wr),
    .host_di(host_di), .host_rd(host_rd), .dr(dr), .rqm(rqm)
  );

  dsp_checker u_chk (
    .CLK(CLK), .chk(chk), .exp_dr(exp_dr), .exp_rqm(exp_rqm), .dr(dr), .rqm(rqm),
    .checks(checks), .errors(errors)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // assembler helpers

  function automatic dsp_pkg::insn_word_t op_word(input logic [1:0] cls,
      input logic [1:0] psel, input logic [3:0] alu, input logic asl,
      input logic rpdcr, input logic [3:0] src, input logic [3:0] dst);
    return {cls, psel, alu, asl, 6'b0, rpdcr, src, dst};
  endfunction

  function automatic dsp_pkg::insn_word_t ld_word(input dsp_pkg::data_t imm,
      input logic [3:0] dst);
    return {2'b11, imm, 2'b00, dst};
  endfunction

  function automatic dsp_pkg::insn_word_t jp_word(input logic [8:0] br, input logic [10:0] na);
    return {2'b10, br, na, 2'b00};
  endfunction

  // expected ALU result with B carry clear
  function automatic dsp_pkg::data_t alu_ref(input int op, input dsp_pkg::data_t x,
      input dsp_pkg::data_t y);
    case (op)
      1:  return x | y;
      2:  return x & y;
      3:  return x ^ y;
      4, 6: return x - y;
      5, 7: return x + y;
      8:  return x - 16'd1;
      9:  return x + 16'd1;
      10: return ~x;
      11: return {x[15], x[15:1]};
      12: return {x[14:0], 1'b0};
      13: return {x[13:0], 2'b11};
      14: return {x[11:0], 4'hf};
      15: return {x[7:0], x[15:8]};
      default: return x;
    endcase
  endfunction

  task automatic build_vectors();
    vec_t v;
    dsp_pkg::data_t x, y;
    logic signed [31:0] prod;
    for (int op = 0; op < 16; op++) begin
      v = '0;
      x = dsp_pkg::data_t'($urandom);
      y = dsp_pkg::data_t'($urandom);
      v.prog[0] = ld_word(x, dsp_pkg::DST_A);
      v.prog[1] = ld_word(y, dsp_pkg::DST_TR);
      v.prog[2] = op_word(dsp_pkg::CLS_OP, dsp_pkg::PSEL_IDB, op[3:0], 1'b0, 1'b0,
                          dsp_pkg::SRC_TR, 4'h0);
      v.prog[3] = op_word(dsp_pkg::CLS_OP, 2'b00, 4'h0, 1'b0, 1'b0, dsp_pkg::SRC_A,
                          dsp_pkg::DST_DR);
      v.prog[4] = jp_word(dsp_pkg::BR_JMP, 11'd4);
      v.nexp = 2'd1;
      v.exp_dr[0] = alu_ref(op, x, y);
      vecs[op] = v;
    end
    // multiplier, M then N
    v = '0;
    x = dsp_pkg::data_t'($urandom);
    y = dsp_pkg::data_t'($urandom);
    prod = $signed(x) * $signed(y);
    v.prog[0] = ld_word(x, dsp_pkg::DST_K);
    v.prog[1] = ld_word(y, dsp_pkg::DST_L);
    v.prog[2] = op_word(dsp_pkg::CLS_OP, dsp_pkg::PSEL_M, dsp_pkg::ALU_OR, 1'b0, 1'b0,
                        dsp_pkg::SRC_TRB, 4'h0);
    v.prog[3] = op_word(dsp_pkg::CLS_OP, 2'b00, 4'h0, 1'b0, 1'b0, dsp_pkg::SRC_A,
                        dsp_pkg::DST_DR);
    v.prog[4] = jp_word(BR_RQM_SET, 11'd4);
    v.prog[5] = op_word(dsp_pkg::CLS_OP, dsp_pkg::PSEL_N, dsp_pkg::ALU_OR, 1'b1, 1'b0,
                        dsp_pkg::SRC_TRB, 4'h0);
    v.prog[6] = op_word(dsp_pkg::CLS_OP, 2'b00, 4'h0, 1'b0, 1'b0, dsp_pkg::SRC_B,
                        dsp_pkg::DST_DR);
    v.prog[7] = jp_word(dsp_pkg::BR_JMP, 11'd7);
    v.nexp = 2'd2;
    v.exp_dr[0] = {prod[31], prod[29:15]};
    v.exp_dr[1] = {prod[14:0], 1'b0};
    vecs[16] = v;
    // data ROM with post-decrement
    v = '0;
    v.rom_addr = 10'(1 + $urandom % 1000);
    v.rom_val[0] = dsp_pkg::data_t'($urandom);
    v.rom_val[1] = dsp_pkg::data_t'($urandom);
    v.prog[0] = ld_word(dsp_pkg::data_t'(v.rom_addr), dsp_pkg::DST_RP);
    v.prog[1] = op_word(dsp_pkg::CLS_OP, 2'b00, 4'h0, 1'b0, 1'b1, dsp_pkg::SRC_ROM,
                        dsp_pkg::DST_DR);
    v.prog[2] = jp_word(BR_RQM_SET, 11'd2);
    v.prog[3] = op_word(dsp_pkg::CLS_OP, 2'b00, 4'h0, 1'b0, 1'b0, dsp_pkg::SRC_ROM,
                        dsp_pkg::DST_DR);
    v.prog[4] = jp_word(dsp_pkg::BR_JMP, 11'd4);
    v.nexp = 2'd2;
    v.exp_dr[0] = v.rom_val[0];
    v.exp_dr[1] = v.rom_val[1];
    vecs[17] = v;
    // Z branch, call and return
    v = '0;
    v.prog[0] = ld_word(dsp_pkg::data_t'($urandom), dsp_pkg::DST_A);
    v.prog[1] = op_word(dsp_pkg::CLS_OP, dsp_pkg::PSEL_IDB, dsp_pkg::ALU_SUB, 1'b0, 1'b0,
                        dsp_pkg::SRC_A, 4'h0);
    v.prog[2] = jp_word(BR_ZA_SET, 11'd4);
    v.prog[3] = ld_word(16'hdead, dsp_pkg::DST_DR);  // not-taken path
    v.prog[4] = jp_word(dsp_pkg::BR_CALL, 11'd7);
    v.prog[5] = ld_word(16'h5a3c, dsp_pkg::DST_DR);
    v.prog[6] = jp_word(dsp_pkg::BR_JMP, 11'd6);
    v.prog[7] = op_word(dsp_pkg::CLS_RT, 2'b00, 4'h0, 1'b0, 1'b0, 4'h0, 4'h0);
    v.nexp = 2'd1;
    v.exp_dr[0] = 16'h5a3c;
    vecs[18] = v;
    // host handshake, DR + 1
    v = '0;
    v.wr_val = dsp_pkg::data_t'($urandom);
    v.prog[0] = ld_word(16'h0001, dsp_pkg::DST_A);
    v.prog[1] = ld_word(16'h0000, dsp_pkg::DST_DR);
    v.prog[2] = jp_word(BR_RQM_SET, 11'd2);
    v.prog[3] = op_word(dsp_pkg::CLS_OP, dsp_pkg::PSEL_IDB, dsp_pkg::ALU_ADD, 1'b0, 1'b0,
                        dsp_pkg::SRC_DR, 4'h0);
    v.prog[4] = jp_word(BR_RQM_SET, 11'd4);
    v.prog[5] = op_word(dsp_pkg::CLS_OP, 2'b00, 4'h0, 1'b0, 1'b0, dsp_pkg::SRC_A,
                        dsp_pkg::DST_DR);
    v.prog[6] = jp_word(dsp_pkg::BR_JMP, 11'd6);
    v.nexp = 2'd3;
    v.wr_en = 1'b1;
    v.exp_dr[0] = 16'h0000;
    v.exp_dr[1] = v.wr_val;
    v.exp_dr[2] = v.wr_val + 16'd1;
    vecs[19] = v;
  endtask

  //////////////////////////////////////////////////
  // stimulus

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic expect_out(input dsp_pkg::data_t d, input logic r);
    chk = 1'b1;
    exp_dr = d;
    exp_rqm = r;
    next_cycle();
    chk = 1'b0;
  endtask

  task automatic wait_rqm(input int idx, input int step, output bit ok);
    ok = 1'b0;
    for (int i = 0; i < 2000 && !ok; i++) begin
      next_cycle();
      ok = rqm;
    end
    if (!ok) begin
      $display("timeout: rqm never went high in entry %0d step %0d", idx, step);
      timeouts++;
    end
  endtask

  task automatic run_entry(input int idx);
    vec_t v;
    bit ok;
    v = vecs[idx];
    RST = 1'b1;
    for (int j = 0; j < 8; j++) begin
      pgm_wr = 1'b1;
      pgm_addr = 11'(j);
      pgm_data = v.prog[j];
      next_cycle();
    end
    pgm_wr = 1'b0;
    for (int j = 0; j < 2; j++) begin
      dat_wr = 1'b1;
      dat_addr = v.rom_addr - 10'(j);
      dat_data = v.rom_val[j];
      next_cycle();
    end
    dat_wr = 1'b0;
    expect_out(16'h0000, 1'b0);  // state held in reset
    RST = 1'b0;
    for (int j = 0; j < v.nexp; j++) begin
      wait_rqm(idx, j, ok);
      if (!ok) return;
      expect_out(v.exp_dr[j], 1'b1);
      if (v.wr_en && j == v.wr_step) begin
        host_wr = 1'b1;
        host_di = v.wr_val;
        next_cycle();
        host_wr = 1'b0;
      end else begin
        host_rd = 1'b1;
        next_cycle();
        host_rd = 1'b0;
      end
    end
    expect_out(v.exp_dr[v.nexp-1], 1'b0);  // rqm cleared by the last strobe
  endtask

  initial begin
    int seed_val;
    RST = 1'b1;
    pgm_wr = 1'b0;
    pgm_addr = '0;
    pgm_data = '0;
    dat_wr = 1'b0;
    dat_addr = '0;
    dat_data = '0;
    host_wr = 1'b0;
    host_di = '0;
    host_rd = 1'b0;
    chk = 1'b0;
    exp_dr = '0;
    exp_rqm = 1'b0;
    timeouts = 0;
    seed_val = $urandom(32'h6ce9f9b0);
    build_vectors();
    next_cycle();
    for (int i = 0; i < NVEC; i++) begin
      run_entry(i);
    end
    next_cycle();
    $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
design/dsp_pkg.sv
design/dsp_mem.sv
design/dsp_sequencer.sv
design/dsp_datapath.sv
design/dsp_alu.sv
design/dsp_core.sv
tests/dsp_checker.sv
tests/dsp_core_assert.sv
tests/tb_dsp_core.sv

// ==== run.sh ====
#!/bin/bash
# build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_dsp_core \
  -Mdir obj_dir -f files.f > build.log 2>&1 \
  && ./obj_dir/Vtb_dsp_core > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
